//--- hdl/merge_config.svh
// ==========================================================================
// Stream merger build-time configuration
// Byte lanes per beat and per-source FIFO capacity
// ==========================================================================

`ifndef MERGE_CONFIG_SVH
`define MERGE_CONFIG_SVH

// Bytes carried by one beat on every port
`define MERGE_LANES 4

// Capacity of each source FIFO in bytes, a multiple of the lane count
`define MERGE_FIFO_DEPTH 16

`endif

//--- hdl/stream_pkg.sv
// ==========================================================================
// Stream beat types
// Bytes, lane counts and the beat formats seen on the merger ports
// ==========================================================================

`include "merge_config.svh"

package stream_pkg;

  // One data byte in a lane
  typedef logic [7:0] lane_byte_t;

  // Number of valid lanes, 0 up to the lane count inclusive
  typedef logic [$clog2(`MERGE_LANES + 1) - 1:0] lane_count_t;

  // Source tag, 0 is source A and 1 is source B
  typedef logic src_id_t;

  // Producer beat
  // Lane 0 holds the oldest byte, lanes at or above count are don't-care
  typedef struct packed {
    lane_count_t                      count;
    lane_byte_t [`MERGE_LANES - 1:0]  data;
  } in_beat_t;

  // Merged beat, all bytes come from the tagged source
  typedef struct packed {
    src_id_t                          src;
    lane_count_t                      count;
    lane_byte_t [`MERGE_LANES - 1:0]  data;
  } out_beat_t;

endpackage

//--- hdl/merge_pkg.sv
// ==========================================================================
// Merge control types
// FIFO occupancy and round-robin arbitration state
// ==========================================================================

`include "merge_config.svh"

package merge_pkg;

  // Bytes held in a lane FIFO, 0 up to the full depth
  typedef logic [$clog2(`MERGE_FIFO_DEPTH + 1) - 1:0] fill_t;

  // Source served last by the arbiter
  // Encoding matches the source tag of the output beat
  typedef enum logic {
    GRANT_A = 1'b0,
    GRANT_B = 1'b1
  } grant_t;

endpackage

//--- hdl/lane_fifo.sv
// ==========================================================================
// Multi-lane byte FIFO
// Circular buffer that takes and gives up several bytes per cycle
// and reports a registered fill level
// ==========================================================================

`timescale 1ns/100ps

`include "merge_config.svh"

module lane_fifo (
  input  logic                                          clk,
  input  logic                                          rstn,
  // Write side, enq_count bytes from lane 0 upward
  input  stream_pkg::lane_count_t                       enq_count,
  input  stream_pkg::lane_byte_t [`MERGE_LANES - 1:0]   enq_data,
  // Read side, deq_count oldest bytes are dropped at the edge
  input  stream_pkg::lane_count_t                       deq_count,
  output merge_pkg::fill_t                              fill_level,
  output stream_pkg::lane_byte_t [`MERGE_LANES - 1:0]   head_data
);

  import stream_pkg::*;
  import merge_pkg::*;

  localparam int LANES = `MERGE_LANES;
  localparam int DEPTH = `MERGE_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  // Depth expressed at the width of a pointer sum
  localparam logic [PTR_W:0] WRAP = (PTR_W + 1)'(DEPTH);

  typedef logic [PTR_W - 1:0] ptr_t;

  // Head is where new bytes land, tail is the oldest stored byte
  ptr_t head_ptr;
  ptr_t tail_ptr;

  // Byte storage
  lane_byte_t [DEPTH - 1:0] mem_q;

  // Pointer advance with wrap at the depth
  // Depth need not be a power of two
  function automatic ptr_t wrap_add(ptr_t ptr, lane_count_t n);
    logic [PTR_W:0] sum;
    sum = ptr + n;
    if (sum >= WRAP) begin
      sum = sum - WRAP;
    end
    return sum[PTR_W - 1:0];
  endfunction

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      head_ptr   <= '0;
      tail_ptr   <= '0;
      fill_level <= '0;
    end else begin
      head_ptr   <= wrap_add(head_ptr, enq_count);
      tail_ptr   <= wrap_add(tail_ptr, deq_count);
      // Net change is bytes in minus bytes out
      fill_level <= fill_level + fill_t'(enq_count) - fill_t'(deq_count);
    end
  end

  // Write up to LANES bytes starting at the head
  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      if (i < enq_count) begin
        mem_q[wrap_add(head_ptr, lane_count_t'(i))] <= enq_data[i];
      end
    end
  end

  // Oldest LANES bytes, lane 0 is the byte at the tail
  // Lanes past fill_level read stale storage
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      head_data[i] = mem_q[wrap_add(tail_ptr, lane_count_t'(i))];
    end
  end

  // Producer side must never overrun the free space
  assert property (@(posedge clk) disable iff (!rstn)
    enq_count <= (fill_t'(DEPTH) - fill_level))
    else $error("lane_fifo overflow, enq %0d with %0d free",
                enq_count, fill_t'(DEPTH) - fill_level);

  // Consumer side never takes more than is stored
  assert property (@(posedge clk) disable iff (!rstn)
    deq_count <= fill_level)
    else $error("lane_fifo underflow, deq %0d with %0d held",
                deq_count, fill_level);

endmodule

//--- hdl/ingress_port.sv
// ==========================================================================
// Ingress port
// Valid/ready front end for one source, accepts a beat only when
// the whole beat fits in its lane FIFO
// ==========================================================================

`timescale 1ns/100ps

`include "merge_config.svh"

module ingress_port (
  input  logic                                          clk,
  input  logic                                          rstn,
  // Producer handshake
  input  logic                                          in_valid,
  output logic                                          in_ready,
  input  stream_pkg::in_beat_t                          in,
  // Arbiter side
  input  stream_pkg::lane_count_t                       deq_count,
  output merge_pkg::fill_t                              fill_level,
  output stream_pkg::lane_byte_t [`MERGE_LANES - 1:0]   head_data
);

  import stream_pkg::*;
  import merge_pkg::*;

  fill_t       free_space;
  lane_count_t enq_count;

  // Free space from the registered fill level
  // No path from in_valid to in_ready
  assign free_space = fill_t'(`MERGE_FIFO_DEPTH) - fill_level;
  assign in_ready   = (free_space >= fill_t'(`MERGE_LANES));

  // Only a taken beat writes, a zero-count beat writes nothing
  assign enq_count = (in_valid && in_ready) ? in.count : '0;

  lane_fifo u_fifo (
    .clk        (clk),
    .rstn       (rstn),
    .enq_count  (enq_count),
    .enq_data   (in.data),
    .deq_count  (deq_count),
    .fill_level (fill_level),
    .head_data  (head_data)
  );

  // Producer never offers more lanes than a beat holds
  assert property (@(posedge clk) disable iff (!rstn)
    in_valid |-> (in.count <= lane_count_t'(`MERGE_LANES)))
    else $error("ingress beat count %0d exceeds lanes", in.count);

  // Stalled beat stays offered and unchanged
  assert property (@(posedge clk) disable iff (!rstn)
    (in_valid && !in_ready) |=> (in_valid && $stable(in)))
    else $error("ingress beat changed while stalled");

endmodule

//--- hdl/merge_arbiter.sv
// ==========================================================================
// Round-robin merge arbiter
// Drains up to one beat of bytes from a single source FIFO per cycle
// into a tagged output register with valid/ready
// ==========================================================================

`timescale 1ns/100ps

`include "merge_config.svh"

module merge_arbiter (
  input  logic                                          clk,
  input  logic                                          rstn,
  // FIFO status and head bytes
  input  merge_pkg::fill_t                              fill_a,
  input  merge_pkg::fill_t                              fill_b,
  input  stream_pkg::lane_byte_t [`MERGE_LANES - 1:0]   head_a,
  input  stream_pkg::lane_byte_t [`MERGE_LANES - 1:0]   head_b,
  // Dequeue requests, at most one nonzero
  output stream_pkg::lane_count_t                       deq_a,
  output stream_pkg::lane_count_t                       deq_b,
  // Merged output
  output logic                                          out_valid,
  input  logic                                          out_ready,
  output stream_pkg::out_beat_t                         out
);

  import stream_pkg::*;
  import merge_pkg::*;

  grant_t      grant_q;
  grant_t      pick;
  logic        has_a;
  logic        has_b;
  logic        load;
  fill_t       pick_fill;
  lane_count_t chunk;

  assign has_a = (fill_a != '0);
  assign has_b = (fill_b != '0);

  // Register is free when empty or being drained this cycle
  assign load = (!out_valid || out_ready) && (has_a || has_b);

  // Contested choice goes to the source not served last
  always_comb begin
    if (has_a && has_b) begin
      pick = (grant_q == GRANT_A) ? GRANT_B : GRANT_A;
    end else if (has_b) begin
      pick = GRANT_B;
    end else begin
      pick = GRANT_A;
    end
  end

  // Chunk is the smaller of stored bytes and one beat
  assign pick_fill = (pick == GRANT_B) ? fill_b : fill_a;
  assign chunk = (pick_fill >= fill_t'(`MERGE_LANES)) ?
                 lane_count_t'(`MERGE_LANES) : lane_count_t'(pick_fill);

  assign deq_a = (load && pick == GRANT_A) ? chunk : '0;
  assign deq_b = (load && pick == GRANT_B) ? chunk : '0;

  // Control state
  // After reset B counts as served, so A wins the first contest
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      grant_q   <= GRANT_B;
      out_valid <= 1'b0;
    end else begin
      if (load) begin
        grant_q   <= pick;
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Output payload, tag follows the grant encoding
  always_ff @(posedge clk) begin
    if (load) begin
      out.src   <= (pick == GRANT_B) ? 1'b1 : 1'b0;
      out.count <= chunk;
      out.data  <= (pick == GRANT_B) ? head_b : head_a;
    end
  end

  // Only one FIFO gives up bytes in any cycle
  assert property (@(posedge clk) disable iff (!rstn)
    !((deq_a != '0) && (deq_b != '0)))
    else $error("both FIFOs dequeued in one cycle");

  // Output beat holds while the consumer stalls
  assert property (@(posedge clk) disable iff (!rstn)
    (out_valid && !out_ready) |=> (out_valid && $stable(out)))
    else $error("output beat changed under back-pressure");

endmodule

//--- hdl/stream_merge_top.sv
// ==========================================================================
// Two-source byte-stream merger
// Two ingress ports with lane FIFOs feeding a round-robin arbiter
// ==========================================================================

`timescale 1ns/100ps

`include "merge_config.svh"

module stream_merge_top (
  input  logic                   clk,
  input  logic                   rstn,
  // Source A
  input  logic                   in_a_valid,
  output logic                   in_a_ready,
  input  stream_pkg::in_beat_t   in_a,
  // Source B
  input  logic                   in_b_valid,
  output logic                   in_b_ready,
  input  stream_pkg::in_beat_t   in_b,
  // Merged output
  output logic                   out_valid,
  input  logic                   out_ready,
  output stream_pkg::out_beat_t  out
);

  import stream_pkg::*;
  import merge_pkg::*;

  // FIFO status toward the arbiter
  fill_t                            fill_a;
  fill_t                            fill_b;
  lane_byte_t [`MERGE_LANES - 1:0]  head_a;
  lane_byte_t [`MERGE_LANES - 1:0]  head_b;

  // Dequeue counts back to the FIFOs
  lane_count_t                      deq_a;
  lane_count_t                      deq_b;

  ingress_port u_ingress_a (
    .clk        (clk),
    .rstn       (rstn),
    .in_valid   (in_a_valid),
    .in_ready   (in_a_ready),
    .in         (in_a),
    .deq_count  (deq_a),
    .fill_level (fill_a),
    .head_data  (head_a)
  );

  ingress_port u_ingress_b (
    .clk        (clk),
    .rstn       (rstn),
    .in_valid   (in_b_valid),
    .in_ready   (in_b_ready),
    .in         (in_b),
    .deq_count  (deq_b),
    .fill_level (fill_b),
    .head_data  (head_b)
  );

  merge_arbiter u_arbiter (
    .clk       (clk),
    .rstn      (rstn),
    .fill_a    (fill_a),
    .fill_b    (fill_b),
    .head_a    (head_a),
    .head_b    (head_b),
    .deq_a     (deq_a),
    .deq_b     (deq_b),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out       (out)
  );

endmodule

//--- test/tb_stream_merge.sv
// ==========================================================================
// Stream merger testbench
// Table-driven beats on both sources, per-source byte scoreboard,
// fairness and back-pressure checks
// ==========================================================================

`timescale 1ns/100ps

`include "merge_config.svh"

module tb_stream_merge;

  import stream_pkg::*;

  localparam int LANES       = `MERGE_LANES;
  localparam int READY_LIMIT = 200;
  localparam int DRAIN_LIMIT = 2000;

  // Stimulus row
  // Its name sits at the same index in names
  typedef struct packed {
    src_id_t     src;
    lane_count_t count;
    lane_byte_t  first;
    logic [7:0]  stall;
  } row_t;

  logic       clk = 1'b0;
  logic       rstn;
  logic       in_a_valid;
  logic       in_a_ready;
  in_beat_t   in_a;
  logic       in_b_valid;
  logic       in_b_ready;
  in_beat_t   in_b;
  logic       out_valid;
  logic       out_ready;
  out_beat_t  out_beat;

  row_t       rows[$];
  string      names[$];
  // Expected bytes per source in arrival order
  lane_byte_t exp_a[$];
  lane_byte_t exp_b[$];
  int         value_errors;
  int         other_errors;
  integer     seed;
  // out_ready control
  // A pending stall count wins over random mode
  int         stall_left;
  logic       rand_stall;
  logic       idle_ready;
  logic       only_a;
  logic       fair_on;
  int         fair_beats;
  // Output beat stalled at the last edge
  logic       held;
  out_beat_t  held_beat;
  string      cur_test;

  stream_merge_top DUT (
    .clk        (clk),
    .rstn       (rstn),
    .in_a_valid (in_a_valid),
    .in_a_ready (in_a_ready),
    .in_a       (in_a),
    .in_b_valid (in_b_valid),
    .in_b_ready (in_b_ready),
    .in_b       (in_b),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out        (out_beat)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  task automatic finish_run();
    $display("Error counts: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  task automatic check_bit(string name, string what, logic exp, logic got);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s: %s expected %b, actual %b", name, what, exp, got);
    end
  endtask

  // Tag checked only when the phase fixes it
  // Count always within one beat
  task automatic check_beat(string name, out_beat_t got, src_id_t exp_src, logic known);
    if (known && got.src !== exp_src) begin
      value_errors++;
      $display("[ERROR] %s: beat tag expected %0d, actual %0d", name, exp_src, got.src);
    end
    if (got.count == 0 || got.count > LANES) begin
      value_errors++;
      $display("[ERROR] %s: beat count expected 1 to %0d, actual %0d",
               name, LANES, got.count);
    end
  endtask

  task automatic check_byte(string name, lane_byte_t exp, lane_byte_t got);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s: byte expected %h, actual %h", name, exp, got);
    end
  endtask

  task automatic check_hold(string name, out_beat_t exp, out_beat_t got);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s: stalled beat expected %h, actual %h", name, exp, got);
    end
  endtask

  // Scoreboard for one transferred output beat
  task automatic take_beat(out_beat_t beat);
    logic    known;
    src_id_t exp_src;
    known   = only_a;
    exp_src = 1'b0;
    // Contested beats alternate and start with A
    if (fair_on && exp_a.size() > 0 && exp_b.size() > 0) begin
      known   = 1'b1;
      exp_src = src_id_t'(fair_beats % 2);
      fair_beats++;
    end
    check_beat(cur_test, beat, exp_src, known);
    for (int i = 0; i < beat.count && i < LANES; i++) begin
      if ((beat.src ? exp_b.size() : exp_a.size()) == 0) begin
        other_errors++;
        $display("Output byte from source %0d arrived with nothing expected in %s",
                 beat.src, cur_test);
      end else if (beat.src) begin
        check_byte(cur_test, exp_b.pop_front(), beat.data[i]);
      end else begin
        check_byte(cur_test, exp_a.pop_front(), beat.data[i]);
      end
    end
  endtask

  // Monitor samples DUT outputs at the edge where they transfer
  always @(posedge clk) begin
    if (!rstn) begin
      held = 1'b0;
    end else begin
      if (held) begin
        if (!out_valid) begin
          other_errors++;
          $display("out_valid dropped while a beat was stalled in %s", cur_test);
        end
        check_hold(cur_test, held_beat, out_beat);
      end
      if (out_valid && out_ready)
        take_beat(out_beat);
      held      = out_valid && !out_ready;
      held_beat = out_beat;
    end
  end

  // Advance to the next falling edge and drive out_ready
  task automatic next_cycle();
    integer rnd;
    @(negedge clk);
    if (stall_left > 0) begin
      out_ready = 1'b0;
      stall_left--;
    end else if (rand_stall) begin
      rnd       = $random(seed);
      out_ready = rnd[0];
    end else begin
      out_ready = idle_ready;
    end
  endtask

  function automatic logic port_ready(src_id_t src);
    return src ? in_b_ready : in_a_ready;
  endfunction

  function automatic logic output_drained();
    return exp_a.size() == 0 && exp_b.size() == 0 && !out_valid;
  endfunction

  // Offer one beat and hold it until taken
  // Its bytes join the expected queue once taken
  task automatic send_beat(string name, src_id_t src, lane_count_t count, lane_byte_t first);
    in_beat_t beat;
    int       waited;
    beat.count = count;
    for (int i = 0; i < LANES; i++)
      beat.data[i] = (i < count) ? first + lane_byte_t'(i) : 8'hee;
    cur_test = name;
    if (src) begin
      in_b       = beat;
      in_b_valid = 1'b1;
    end else begin
      in_a       = beat;
      in_a_valid = 1'b1;
    end
    waited = 0;
    while (!port_ready(src) && waited < READY_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (!port_ready(src)) begin
      other_errors++;
      $display("Source %0d never became ready in %s", src, name);
      finish_run();
    end else begin
      for (int i = 0; i < count; i++) begin
        if (src)
          exp_b.push_back(first + lane_byte_t'(i));
        else
          exp_a.push_back(first + lane_byte_t'(i));
      end
      next_cycle();
      in_a_valid = 1'b0;
      in_b_valid = 1'b0;
    end
  endtask

  // Wait until every expected byte has come out and the output is empty
  task automatic wait_drained(string name);
    int waited;
    waited = 0;
    while (!output_drained() && waited < DRAIN_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (!output_drained()) begin
      other_errors++;
      $display("Output did not drain in %s, %0d A and %0d B bytes still expected",
               name, exp_a.size(), exp_b.size());
      finish_run();
    end
  endtask

  task automatic add_row(string name, src_id_t src, lane_count_t count,
                         lane_byte_t first, int stall);
    row_t row;
    row.src   = src;
    row.count = count;
    row.first = first;
    row.stall = 8'(stall);
    names.push_back(name);
    rows.push_back(row);
  endtask

  task automatic apply_rows(int lo, int hi);
    for (int r = lo; r < hi; r++) begin
      send_beat(names[r], rows[r].src, rows[r].count, rows[r].first);
      stall_left = rows[r].stall;
    end
  endtask

  initial begin
    integer rnd;
    seed         = 32'hcc2f_2b0b;
    value_errors = 0;
    other_errors = 0;
    stall_left   = 0;
    rand_stall   = 1'b0;
    idle_ready   = 1'b1;
    only_a       = 1'b0;
    fair_on      = 1'b0;
    fair_beats   = 0;
    held         = 1'b0;
    cur_test     = "reset";
    rstn         = 1'b0;
    in_a_valid   = 1'b0;
    in_b_valid   = 1'b0;
    in_a         = '0;
    in_b         = '0;
    out_ready    = 1'b0;

    // Rows 0 to 7 on source A only with every count
    add_row("order_c3", 1'b0, 3'd3, 8'h10, 0);
    add_row("order_c0", 1'b0, 3'd0, 8'h20, 0);
    add_row("order_c4", 1'b0, 3'd4, 8'h30, 3);
    add_row("order_c1", 1'b0, 3'd1, 8'h40, 0);
    add_row("order_c2", 1'b0, 3'd2, 8'h48, 0);
    add_row("order_c4b", 1'b0, 3'd4, 8'h50, 0);
    add_row("order_c0b", 1'b0, 3'd0, 8'h58, 2);
    add_row("order_c3b", 1'b0, 3'd3, 8'h60, 0);
    // Rows 8 to 17 interleave the sources
    add_row("mix_a4", 1'b0, 3'd4, 8'h70, 0);
    add_row("mix_b2", 1'b1, 3'd2, 8'h80, 0);
    add_row("mix_b4", 1'b1, 3'd4, 8'h84, 0);
    add_row("mix_a1", 1'b0, 3'd1, 8'h74, 0);
    add_row("mix_a3", 1'b0, 3'd3, 8'h75, 5);
    add_row("mix_b0", 1'b1, 3'd0, 8'h88, 0);
    add_row("mix_b3", 1'b1, 3'd3, 8'h89, 0);
    add_row("mix_a2", 1'b0, 3'd2, 8'h78, 2);
    add_row("mix_b4b", 1'b1, 3'd4, 8'h8c, 0);
    add_row("mix_a4b", 1'b0, 3'd4, 8'h7a, 0);
    // Rows 18 to 26 leave one beat in the output register and both FIFOs full
    for (int i = 0; i < 5; i++)
      add_row("fair_a", 1'b0, 3'd4, 8'hc0 + 8'(4 * i), 0);
    for (int i = 0; i < 4; i++)
      add_row("fair_b", 1'b1, 3'd4, 8'h30 + 8'(4 * i), 0);

    repeat (4) next_cycle();
    rstn = 1'b1;
    next_cycle();
    check_bit("reset", "out_valid", 1'b0, out_valid);
    check_bit("reset", "in_a_ready", 1'b1, in_a_ready);
    check_bit("reset", "in_b_ready", 1'b1, in_b_ready);

    only_a = 1'b1;
    apply_rows(0, 8);
    wait_drained("order");
    only_a = 1'b0;
    apply_rows(8, 18);
    wait_drained("mix");

    // Fill under back-pressure and then release
    idle_ready = 1'b0;
    fair_on    = 1'b1;
    next_cycle();
    apply_rows(18, 27);
    check_bit("fair_full", "in_a_ready", 1'b0, in_a_ready);
    check_bit("fair_full", "in_b_ready", 1'b0, in_b_ready);
    check_bit("fair_full", "out_valid", 1'b1, out_valid);
    repeat (3) next_cycle();
    idle_ready = 1'b1;
    wait_drained("fair");
    fair_on = 1'b0;
    if (fair_beats == 0) begin
      other_errors++;
      $display("Fairness phase saw no beats while both sources held data");
    end

    // Random beats and random output stalls
    rand_stall = 1'b1;
    for (int n = 0; n < 40; n++) begin
      rnd = $random(seed);
      send_beat("random", rnd[0], lane_count_t'(rnd[15:1] % 5), rnd[23:16]);
    end
    wait_drained("random");
    rand_stall = 1'b0;

    finish_run();
  end

endmodule

//--- filelist.f
+incdir+hdl
hdl/stream_pkg.sv
hdl/merge_pkg.sv
hdl/lane_fifo.sv
hdl/ingress_port.sv
hdl/merge_arbiter.sv
hdl/stream_merge_top.sv
test/tb_stream_merge.sv

//--- run_sim.sh
#!/bin/sh
# Builds the stream merger testbench with Verilator and runs it into sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_stream_merge \
  -Mdir obj_dir -o tb_stream_merge
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_stream_merge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
